/* design/rom_loader_pkg.sv */
//========================================
// ROM loader shared definitions
// Widths, ROM base offset, beat views and port structs
//========================================

package rom_loader_pkg;

	localparam int ROM_ADDR_W = 27;  // ROM byte address width
	localparam int BEAT_BYTES = 8;   // One DDR beat
	localparam int WORD_BYTES = 4;   // One SDRAM word

	// Game ROM sits at the same byte offset in DDR and SDRAM
	localparam logic [ROM_ADDR_W-1:0] ROM_BASE_BYTE = 27'd786432;

	//========================================
	// Beat views
	//========================================

	// Index 0 is the low half in both views
	typedef union packed {
		logic [1:0][31:0] dword;  // SDRAM write path
		logic [3:0][15:0] half;   // Header scan path
	} rom_beat_u;

	//========================================
	// Port structs
	//========================================

	typedef struct packed {
		logic                  req;
		logic [ROM_ADDR_W-3:0] addr;  // Dword address
		logic [31:0]           data;
	} sd_wr_t;

	typedef struct packed {
		logic                  req;
		logic [ROM_ADDR_W-4:0] addr;  // Qword address
	} ddr_rd_t;

	typedef struct packed {
		logic                  wr;
		logic [ROM_ADDR_W-1:0] addr;  // ROM byte address
		logic [15:0]           data;
	} rom_half_t;

	typedef struct packed {
		logic sram_off;      // Hide SRAM from the game
		logic memory_remap;  // Mirror a small ROM over the full range
		logic gpio;
		logic tilt;
		logic solar;
		logic sprite_limit;  // Enforce the per-line sprite pixel budget
	} cart_quirks_t;

endpackage

/* design/romcopy_sequencer.sv */
//========================================
// ROM copy sequencer
// Paces DDR beat reads and the two SDRAM
// dword writes that follow each beat
//========================================
`timescale 1ns/1ps

module romcopy_sequencer (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      download_done,
	input  logic                      sdram_en,
	input  logic                      ddr_ack,
	input  logic                      sd_ack,
	input  logic                      last_beat,
	input  rom_loader_pkg::rom_beat_u beat_in,
	output logic                      ddr_req,
	output logic                      read_step,
	output logic                      write_step,
	output logic                      stream_load,
	output logic                      copy_active,
	output logic                      sd_req_lo,  // SDRAM write strobe, once per dword
	output logic [31:0]               sd_data
);

	typedef enum logic [2:0] {
		st_idle,
		st_issue,
		st_wait_ddr,
		st_write_lo,
		st_write_hi
	} state_t;

	state_t                    state;
	rom_loader_pkg::rom_beat_u beat_q;
	logic                      write_done;
	logic                      in_write;

	assign read_step   = (state == st_wait_ddr) && ddr_ack;
	assign stream_load = read_step;  // Stream takes the beat straight off the DDR bus

	// Without SDRAM each write state passes in one cycle
	assign write_done = sd_ack || !sdram_en;
	assign in_write   = (state == st_write_lo) || (state == st_write_hi);
	assign write_step = in_write && write_done;

	//========================================
	// State machine
	//========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= st_idle;
			copy_active <= 1'b0;
			ddr_req     <= 1'b0;
			sd_req_lo   <= 1'b0;
		end else begin
			ddr_req   <= 1'b0;
			sd_req_lo <= 1'b0;
			case (state)
				st_idle: begin
					if (download_done) begin
						state       <= st_issue;
						copy_active <= 1'b1;
					end
				end
				st_issue: begin
					if (last_beat) begin  // Whole ROM read
						state       <= st_idle;
						copy_active <= 1'b0;
					end else begin
						ddr_req <= 1'b1;
						state   <= st_wait_ddr;
					end
				end
				st_wait_ddr: begin
					if (ddr_ack) begin
						state     <= st_write_lo;
						sd_req_lo <= sdram_en;
					end
				end
				st_write_lo: begin
					if (write_done) begin
						state     <= st_write_hi;
						sd_req_lo <= sdram_en;
					end
				end
				st_write_hi: begin
					if (write_done)
						state <= st_issue;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Beat and outgoing dword
	always_ff @(posedge clk_sys) begin
		if (read_step) begin
			beat_q  <= beat_in;
			sd_data <= beat_in.dword[0];
		end else if ((state == st_write_lo) && write_done) begin
			sd_data <= beat_q.dword[1];
		end
	end

	// DDR traffic stays inside the copy window
	a_ddr_in_copy: assert property (@(posedge clk_sys) disable iff (reset)
		ddr_req |-> copy_active);

	// SDRAM stays untouched while it is disabled
	a_sd_needs_en: assert property (@(posedge clk_sys) disable iff (reset)
		sd_req_lo |-> sdram_en);

endmodule

/* design/copy_address_counter.sv */
//========================================
// Copy address counter
// Read and write byte positions of the copy
//========================================
`timescale 1ns/1ps

module copy_address_counter (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  download_done,
	input  logic                                  read_step,
	input  logic                                  write_step,
	input  logic [rom_loader_pkg::ROM_ADDR_W-1:0] rom_size,
	output logic [rom_loader_pkg::ROM_ADDR_W-1:0] read_pos,
	output logic [rom_loader_pkg::ROM_ADDR_W-1:0] write_pos,
	output logic                                  last_beat
);

	logic [rom_loader_pkg::ROM_ADDR_W-1:0] size_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			size_q    <= '0;
			read_pos  <= '0;
			write_pos <= '0;
		end else if (download_done) begin  // New cart starts from byte 0
			size_q    <= rom_size;
			read_pos  <= '0;
			write_pos <= '0;
		end else begin
			if (read_step)
				read_pos <= read_pos + rom_loader_pkg::ROM_ADDR_W'(rom_loader_pkg::BEAT_BYTES);
			if (write_step)
				write_pos <= write_pos + rom_loader_pkg::ROM_ADDR_W'(rom_loader_pkg::WORD_BYTES);
		end
	end

	// A partial last beat is still read in full
	assign last_beat = (read_pos >= size_q);

endmodule

/* design/rom_halfword_stream.sv */
//========================================
// ROM halfword stream
// Replays a copied beat as four addressed halfwords
//========================================
`timescale 1ns/1ps

module rom_halfword_stream (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  load,
	input  rom_loader_pkg::rom_beat_u             beat,
	input  logic [rom_loader_pkg::ROM_ADDR_W-1:0] base_addr,
	output rom_loader_pkg::rom_half_t             half
);

	logic [2:0][15:0]                      pending;  // Halfwords not yet sent
	logic [1:0]                            count;
	logic                                  wr_q;
	logic [rom_loader_pkg::ROM_ADDR_W-1:0] addr_q;
	logic [15:0]                           data_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_q  <= 1'b0;
			count <= '0;
		end else if (load) begin
			wr_q  <= 1'b1;
			count <= 2'd3;
		end else begin
			wr_q <= (count != '0);
			if (count != '0)
				count <= count - 2'd1;
		end
	end

	// First halfword leaves on the load edge, the rest shift down
	always_ff @(posedge clk_sys) begin
		if (load) begin
			data_q  <= beat.half[0];
			addr_q  <= base_addr;
			pending <= beat.half[3:1];
		end else if (count != '0) begin
			data_q  <= pending[0];
			addr_q  <= addr_q + rom_loader_pkg::ROM_ADDR_W'(2);
			pending <= {16'h0000, pending[2:1]};
		end
	end

	assign half = '{wr: wr_q, addr: addr_q, data: data_q};

	// Sequencer spacing must leave room for all four halfwords
	a_load_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		load |-> (count == '0));

endmodule

/* design/cart_header_scan.sv */
//========================================
// Cartridge header scanner
// Finds the FLASH1M_V save tag, captures the
// game id and decodes compatibility quirks
//========================================
`timescale 1ns/1ps

module cart_header_scan (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         download_done,
	input  rom_loader_pkg::rom_half_t    half,
	output logic                         flash_1m,
	output rom_loader_pkg::cart_quirks_t quirks
);

	logic [63:0] history;  // Last eight ROM bytes, newest in the low byte
	logic [31:0] cart_id;  // Game code in file order
	logic [15:0] swapped;
	logic        tag_even;
	logic        tag_odd;

	//========================================
	// Quirk table
	//========================================

	function automatic rom_loader_pkg::cart_quirks_t decode_quirks(input logic [31:0] id);
		rom_loader_pkg::cart_quirks_t q;
		q = '0;
		if (id[31:8] == "AR8" || id[31:8] == "ALG" || id[31:8] == "AI2")
			q.sram_off = 1'b1;  // Games that probe SRAM as emulator detection
		if (id[31:8] == "BPE" || id[31:8] == "AXV")
			q.gpio = 1'b1;      // RTC on GPIO lines
		if (id[31:8] == "BHG")
			q.sprite_limit = 1'b1;
		if (id[31:24] == "K")
			q.tilt = 1'b1;      // Tilt sensor carts
		if (id[31:24] == "U") begin  // Solar sensor carts
			q.gpio  = 1'b1;
			q.solar = 1'b1;
		end
		if (id[31:24] == "F") begin  // NES classics
			q.sram_off     = 1'b1;
			q.memory_remap = 1'b1;
			if (id == "FMRJ") begin
				q.memory_remap = 1'b0;
				q.sprite_limit = 1'b1;
			end
		end
		return q;
	endfunction

	// Byte at the even address sits in the low half
	assign swapped  = {half.data[7:0], half.data[15:8]};
	assign tag_even = ({history, half.data[7:0]} == "FLASH1M_V");
	assign tag_odd  = ({history[55:0], swapped} == "FLASH1M_V");

	always_ff @(posedge clk_sys) begin
		if (reset || download_done) begin
			flash_1m <= 1'b0;
			quirks   <= '0;
		end else if (half.wr) begin
			if (tag_even || tag_odd)
				flash_1m <= 1'b1;
			if (half.addr == rom_loader_pkg::ROM_ADDR_W'('hB0))  // First halfword after the id
				quirks <= decode_quirks(cart_id);
		end
	end

	// Cleared per cart so a tag never spans two images
	always_ff @(posedge clk_sys) begin
		if (reset || download_done)
			history <= '0;
		else if (half.wr)
			history <= {history[47:0], swapped};
	end

	//========================================
	// Game id capture, bytes 0xAC to 0xAF
	//========================================

	always_ff @(posedge clk_sys) begin
		if (half.wr) begin
			if (half.addr == rom_loader_pkg::ROM_ADDR_W'('hAC))
				cart_id[31:16] <= swapped;
			if (half.addr == rom_loader_pkg::ROM_ADDR_W'('hAE))
				cart_id[15:0] <= swapped;
		end
	end

endmodule

/* design/rom_loader.sv */
//========================================
// Cartridge ROM loader
// Copies the ROM from DDR to SDRAM and scans its header
//========================================
`timescale 1ns/1ps

module rom_loader (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  download_done,
	input  logic [rom_loader_pkg::ROM_ADDR_W-1:0] rom_size,
	input  logic                                  sdram_en,
	input  logic                                  ddr_ack,
	input  logic [63:0]                           ddr_data,
	input  logic                                  sd_ack,
	output rom_loader_pkg::ddr_rd_t               ddr_rd,
	output rom_loader_pkg::sd_wr_t                sd_wr,
	output logic                                  copy_active,
	output logic                                  flash_1m,
	output rom_loader_pkg::cart_quirks_t          quirks
);

	logic                                  ddr_req;
	logic                                  read_step;
	logic                                  write_step;
	logic                                  stream_load;
	logic                                  sd_req;
	logic                                  last_beat;
	logic [31:0]                           sd_data;
	logic [rom_loader_pkg::ROM_ADDR_W-1:0] read_pos;
	logic [rom_loader_pkg::ROM_ADDR_W-1:0] write_pos;
	logic [rom_loader_pkg::ROM_ADDR_W-1:0] ddr_byte;
	logic [rom_loader_pkg::ROM_ADDR_W-1:0] sd_byte;
	logic [rom_loader_pkg::ROM_ADDR_W-4:0] ddr_addr_hold;
	logic [rom_loader_pkg::ROM_ADDR_W-3:0] sd_addr_hold;
	rom_loader_pkg::rom_half_t             half;

	romcopy_sequencer u_seq (
		.clk_sys(clk_sys), .reset(reset), .download_done(download_done),
		.sdram_en(sdram_en), .ddr_ack(ddr_ack), .sd_ack(sd_ack),
		.last_beat(last_beat), .beat_in(ddr_data), .ddr_req(ddr_req),
		.read_step(read_step), .write_step(write_step), .stream_load(stream_load),
		.copy_active(copy_active), .sd_req_lo(sd_req), .sd_data(sd_data)
	);

	copy_address_counter u_cnt (
		.clk_sys(clk_sys), .reset(reset), .download_done(download_done),
		.read_step(read_step), .write_step(write_step), .rom_size(rom_size),
		.read_pos(read_pos), .write_pos(write_pos), .last_beat(last_beat)
	);

	// Beat address is the read position before its step
	rom_halfword_stream u_stream (
		.clk_sys(clk_sys), .reset(reset), .load(stream_load),
		.beat(ddr_data), .base_addr(read_pos), .half(half)
	);

	cart_header_scan u_scan (
		.clk_sys(clk_sys), .reset(reset), .download_done(download_done),
		.half(half), .flash_1m(flash_1m), .quirks(quirks)
	);

	//========================================
	// Memory addresses
	//========================================

	assign ddr_byte = rom_loader_pkg::ROM_BASE_BYTE + read_pos;
	assign sd_byte  = rom_loader_pkg::ROM_BASE_BYTE + write_pos;

	// Positions move on ack, so keep the address of the last request
	always_ff @(posedge clk_sys) begin
		if (ddr_req)
			ddr_addr_hold <= ddr_byte[rom_loader_pkg::ROM_ADDR_W-1:3];
		if (sd_req)
			sd_addr_hold <= sd_byte[rom_loader_pkg::ROM_ADDR_W-1:2];
	end

	assign ddr_rd.req  = ddr_req;
	assign ddr_rd.addr = ddr_req ? ddr_byte[rom_loader_pkg::ROM_ADDR_W-1:3] : ddr_addr_hold;
	assign sd_wr.req   = sd_req;
	assign sd_wr.addr  = sd_req ? sd_byte[rom_loader_pkg::ROM_ADDR_W-1:2] : sd_addr_hold;
	assign sd_wr.data  = sd_data;

endmodule

/* dv/rom_loader_tb.sv */
//========================================
// ROM loader testbench
// DDR and SDRAM models, cart stimulus and
// assertion checks on copy and header results
//========================================
`timescale 1ns/1ps

module rom_loader_tb;

	localparam int CLK_NS      = 8;
	localparam int NUM_CARTS   = 6;
	localparam int MAX_BEATS   = 128;
	localparam int IMG_BYTES   = MAX_BEATS * rom_loader_pkg::BEAT_BYTES;
	localparam int WATCHDOG_NS = NUM_CARTS * MAX_BEATS * 20 * CLK_NS;
	localparam int ROM_BASE    = int'(rom_loader_pkg::ROM_BASE_BYTE);
	localparam int BASE_QWORD  = ROM_BASE / rom_loader_pkg::BEAT_BYTES;
	localparam int BASE_DWORD  = ROM_BASE / rom_loader_pkg::WORD_BYTES;
	localparam logic [71:0] FLASH_TAG = "FLASH1M_V";

	//========================================
	// Cart list
	//========================================

	logic [31:0] id_tab    [NUM_CARTS] = '{"AR8E", "KXYZ", "UABC", "FADJ", "FMRJ", "ZZZZ"};
	int          size_tab  [NUM_CARTS] = '{768, 1024, 517, 300, 1000, 181};
	logic        en_tab    [NUM_CARTS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
	int          tag_tab   [NUM_CARTS] = '{'h40, 'h121, -1, -1, 'h2A, -1};  // -1 means no tag
	logic        flash_tab [NUM_CARTS] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
	// Bits are sram_off, memory_remap, gpio, tilt, solar, sprite_limit
	rom_loader_pkg::cart_quirks_t quirk_tab [NUM_CARTS] = '{
		6'b100000, 6'b000100, 6'b001010, 6'b110000, 6'b100001, 6'b000000
	};

	logic                                  clk_sys;
	logic                                  reset;
	logic                                  download_done;
	logic [rom_loader_pkg::ROM_ADDR_W-1:0] rom_size;
	logic                                  sdram_en;
	logic                                  ddr_ack;
	logic [63:0]                           ddr_data;
	logic                                  sd_ack;
	rom_loader_pkg::ddr_rd_t               ddr_rd;
	rom_loader_pkg::sd_wr_t                sd_wr;
	logic                                  copy_active;
	logic                                  flash_1m;
	rom_loader_pkg::cart_quirks_t          quirks;

	logic [7:0]                   rom_img [IMG_BYTES];
	logic [31:0]                  shadow [IMG_BYTES/4];  // Words the SDRAM model received
	int                           rd_count = 0;          // Owned by the DDR model
	int                           wr_count = 0;          // Owned by the SDRAM model
	int                           rd_first = 0;
	int                           wr_first = 0;
	int                           errors = 0;
	int                           exp_beats;
	logic                         exp_en;
	logic                         exp_flash;
	rom_loader_pkg::cart_quirks_t exp_quirks;

	rom_loader dut (
		.clk_sys(clk_sys), .reset(reset), .download_done(download_done),
		.rom_size(rom_size), .sdram_en(sdram_en), .ddr_ack(ddr_ack),
		.ddr_data(ddr_data), .sd_ack(sd_ack), .ddr_rd(ddr_rd), .sd_wr(sd_wr),
		.copy_active(copy_active), .flash_1m(flash_1m), .quirks(quirks)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS/2) clk_sys = ~clk_sys;
	end

	// Little endian, byte at the lowest address in bits 7:0
	function automatic logic [63:0] img_qword(input int q);
		logic [63:0] v;
		for (int i = 0; i < 8; i++)
			v[8*i +: 8] = rom_img[8*q + i];
		return v;
	endfunction

	function automatic logic [31:0] img_dword(input int k);
		return {rom_img[4*k + 3], rom_img[4*k + 2], rom_img[4*k + 1], rom_img[4*k]};
	endfunction

	function automatic logic shadow_matches(input int words);
		logic ok;
		ok = 1'b1;
		for (int k = 0; k < words; k++)
			if (shadow[k] !== img_dword(k))
				ok = 1'b0;
		return ok;
	endfunction

	task automatic flag_error(input string what);
		errors++;
		$display("ERR %0t: %s", $time, what);
	endtask

	task automatic build_image(input logic [31:0] id, input int tag_at);
		for (int i = 0; i < IMG_BYTES; i++)
			rom_img[i] = 8'($urandom);
		for (int i = 0; i < 4; i++)
			rom_img['hAC + i] = id[31-8*i -: 8];  // Game code in file order
		if (tag_at >= 0)
			for (int i = 0; i < 9; i++)
				rom_img[tag_at + i] = FLASH_TAG[71-8*i -: 8];
	endtask

	//========================================
	// Memory models
	//========================================

	initial begin : ddr_model
		int qword;
		ddr_ack  = 1'b0;
		ddr_data = '0;
		forever begin
			@(negedge clk_sys);
			if (ddr_rd.req) begin
				qword = int'(ddr_rd.addr) - BASE_QWORD;
				repeat ($urandom_range(6, 1) - 1) @(negedge clk_sys);
				ddr_ack  = 1'b1;
				ddr_data = img_qword(qword);
				@(negedge clk_sys);
				ddr_ack  = 1'b0;
				rd_count = rd_count + 1;
			end
		end
	end

	// High dword request can arrive on the same edge that drops the ack
	initial begin : sdram_model
		int idx;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_ack) begin
				sd_ack   = 1'b0;
				wr_count = wr_count + 1;
			end
			if (sd_wr.req) begin
				idx = int'(sd_wr.addr) - BASE_DWORD;
				if (idx >= 0 && idx < IMG_BYTES/4)
					shadow[idx] = sd_wr.data;
				repeat ($urandom_range(5, 1) - 1) @(negedge clk_sys);
				sd_ack = 1'b1;
			end
		end
	end

	//========================================
	// Checks
	//========================================

	a_ddr_addr: assert property (@(posedge clk_sys) disable iff (reset)
		ddr_rd.req |-> ddr_rd.addr == 24'(BASE_QWORD + rd_count - rd_first))
		else flag_error("DDR read address out of sequence");
	a_sd_write: assert property (@(posedge clk_sys) disable iff (reset)
		sd_wr.req |-> sd_wr.addr == 25'(BASE_DWORD + wr_count - wr_first)
			&& sd_wr.data == img_dword(wr_count - wr_first))
		else flag_error("SDRAM write address or data differs from the ROM image");
	a_start: assert property (@(posedge clk_sys) disable iff (reset)
		download_done |=> copy_active)
		else flag_error("copy_active did not rise after download_done");
	a_rise: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(copy_active) |-> $past(download_done))
		else flag_error("copy_active rose without download_done");
	a_first_read: assert property (@(posedge clk_sys) disable iff (reset)
		download_done |-> ##2 ddr_rd.req)
		else flag_error("first DDR read not two cycles after download_done");
	a_in_window: assert property (@(posedge clk_sys) disable iff (reset)
		(ddr_rd.req || sd_wr.req) |-> copy_active)
		else flag_error("memory request outside the copy window");
	a_sd_off: assert property (@(posedge clk_sys) disable iff (reset)
		!sdram_en |-> !sd_wr.req)
		else flag_error("SDRAM write while sdram_en is low");
	a_counts: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(copy_active) |-> (rd_count - rd_first == exp_beats)
			&& (wr_count - wr_first == (exp_en ? 2*exp_beats : 0)))
		else flag_error("read or write count at end of copy is wrong");
	a_shadow: assert property (@(posedge clk_sys) disable iff (reset)
		($fell(copy_active) && exp_en) |-> shadow_matches(2*exp_beats))
		else flag_error("SDRAM shadow differs from the ROM image");
	a_header: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(copy_active) |-> ##5 (flash_1m == exp_flash && quirks == exp_quirks))
		else flag_error("flash_1m or quirks differ from the header rules");

	//========================================
	// Stimulus
	//========================================

	initial begin : stimulus
		void'($urandom(70108));
		reset         = 1'b1;
		download_done = 1'b0;
		rom_size      = '0;
		sdram_en      = 1'b1;
		exp_beats     = 0;
		exp_en        = 1'b1;
		exp_flash     = 1'b0;
		exp_quirks    = '0;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		repeat (4) @(negedge clk_sys);
		for (int c = 0; c < NUM_CARTS; c++) begin
			build_image(id_tab[c], tag_tab[c]);
			exp_beats  = (size_tab[c] + rom_loader_pkg::BEAT_BYTES - 1)
				/ rom_loader_pkg::BEAT_BYTES;  // Partial last beat counts
			exp_en     = en_tab[c];
			exp_flash  = flash_tab[c];
			exp_quirks = quirk_tab[c];
			rd_first   = rd_count;
			wr_first   = wr_count;
			download_done = 1'b1;
			rom_size      = 27'(size_tab[c]);
			sdram_en      = en_tab[c];
			@(negedge clk_sys);
			download_done = 1'b0;
			while (copy_active)
				@(negedge clk_sys);
			repeat (12) @(negedge clk_sys);  // Header check lands in this gap
		end
		$display("Carts %0d, DDR reads %0d, SDRAM writes %0d, errors %0d",
			NUM_CARTS, rd_count, wr_count, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: the ROM copies did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* flist.f */
design/rom_loader_pkg.sv
design/romcopy_sequencer.sv
design/copy_address_counter.sv
design/rom_halfword_stream.sv
design/cart_header_scan.sv
design/rom_loader.sv
dv/rom_loader_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ROM loader testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=rom_loader_sim
LOG_FILE=sim.log

verilator --binary --timing --assert --top-module rom_loader_tb \
	-f flist.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG_FILE"; then
	exit 0
fi
exit 1
